// File: source/cpu_config.svh
/* front end configuration
   word width, queue depth and the first fetch address */

`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// instruction and address width
`define WORD_W 32

// bytes per word, for the wishbone select lines
`define WORD_BYTES (`WORD_W / 8)

// entries in each of the two queues
`define QUEUE_DEPTH 4

// fetch starts here after reset
`define RESET_PC 32'h0000_0000

`endif

// File: source/cpu_types_pkg.sv
/* front end types
   opcodes, function codes, control enums and the packet and bundle structs */

`default_nettype none

`include "cpu_config.svh"

package cpu_types_pkg;

    typedef logic [`WORD_W-1:0] word_t;

    typedef enum logic [6:0] {
        OP_RTYPE    = 7'b0110011,
        OP_ITYPE    = 7'b0010011,
        OP_ITYPE_LW = 7'b0000011,
        OP_STYPE    = 7'b0100011,
        OP_BTYPE    = 7'b1100011,
        OP_JAL      = 7'b1101111,
        OP_JALR     = 7'b1100111,
        OP_LUI      = 7'b0110111,
        OP_HALT     = 7'b1111111,
        OP_LD_M     = 7'b1000111,
        OP_ST_M     = 7'b1010111,
        OP_GEMM_M   = 7'b1110111
    } opcode_t;

    // funct3 for register and immediate alu ops
    typedef enum logic [2:0] {
        F3_ADD_SUB = 3'h0,
        F3_SLL     = 3'h1,
        F3_SLT     = 3'h2,
        F3_SLTU    = 3'h3,
        F3_XOR     = 3'h4,
        F3_SRL_SRA = 3'h5,
        F3_OR      = 3'h6,
        F3_AND     = 3'h7
    } funct3_alu_t;

    typedef enum logic [2:0] {
        F3_BEQ  = 3'h0,
        F3_BNE  = 3'h1,
        F3_BLT  = 3'h4,
        F3_BGE  = 3'h5,
        F3_BLTU = 3'h6,
        F3_BGEU = 3'h7
    } funct3_branch_t;

    // only word width loads and stores exist
    localparam logic [2:0] F3_WORD = 3'h2;

    // funct7 selecting sub and sra
    localparam logic [6:0] F7_ALT = 7'b0100000;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SRL, ALU_SRA,
        ALU_AND, ALU_OR, ALU_XOR, ALU_SLT, ALU_SLTU
    } alu_op_t;

    typedef enum logic [2:0] {
        BR_NONE, BR_BEQ, BR_BNE, BR_BLT, BR_BGE, BR_BLTU, BR_BGEU
    } branch_t;

    typedef enum logic [1:0] {FU_S_NONE, FU_S_ALU, FU_S_LD_ST, FU_S_BRANCH} fu_s_t;

    typedef enum logic [1:0] {FU_M_NONE, FU_M_LD_ST, FU_M_GEMM} fu_m_t;

    typedef enum logic [1:0] {MEM_NONE, MEM_LOAD, MEM_STORE} mem_type_t;

    typedef struct packed {
        word_t pc;
        word_t instr;
    } fetch_packet_t;

    typedef struct packed {
        word_t      pc;
        logic       halt;
        logic       i_flag;
        logic       reg_write;
        logic       mem_to_reg;
        logic       jal;
        logic       jalr;
        logic       u_load;
        mem_type_t  s_mem_type;
        alu_op_t    alu_op;
        branch_t    branch_type;
        word_t      imm;
        logic [4:0] stride;
        fu_s_t      fu_s;
        fu_m_t      fu_m;
        mem_type_t  m_mem_type;
        logic [3:0] matrix_rd;
    } decoded_t;

endpackage

`default_nettype wire

// File: source/instr_fetch.sv
/* instruction fetch
   wishbone classic master reading sequential words into the instruction queue */

`timescale 1ns/100ps
`default_nettype none

`include "cpu_config.svh"

module instr_fetch
(
    input  logic                          clk,
    input  logic                          reset,
    output logic                          wb_cyc,
    output logic                          wb_stb,
    output logic                          wb_we,
    output logic [`WORD_W-1:0]            wb_adr,
    output logic [`WORD_BYTES-1:0]        wb_sel,
    input  logic [`WORD_W-1:0]            wb_dat_r,
    input  logic                          wb_ack,
    input  logic                          q_full,
    input  logic                          q_almost_full,
    output logic                          q_push,
    output cpu_types_pkg::fetch_packet_t  q_data,
    input  logic                          halted
);
    import cpu_types_pkg::*;

    typedef enum logic {FETCH_IDLE, FETCH_BUSY} fetch_state_t;

    fetch_state_t state;
    word_t        pc;
    logic         start_ok;
    logic         start;

    assign start = (state == FETCH_IDLE) && start_ok && !halted;

    // one read at a time, address held until ack
    assign wb_cyc = (state == FETCH_BUSY);
    assign wb_stb = (state == FETCH_BUSY);
    assign wb_we  = 1'b0;
    assign wb_adr = pc;
    assign wb_sel = '1;

    assign q_push = (state == FETCH_BUSY) && wb_ack;
    assign q_data = '{pc: pc, instr: wb_dat_r};

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state    <= FETCH_IDLE;
            pc       <= `RESET_PC;
            start_ok <= 1'b0;
        end
        else
        begin
            case (state)
                FETCH_IDLE:
                begin
                    if (start)
                        state <= FETCH_BUSY;
                end
                FETCH_BUSY:
                begin
                    if (wb_ack)
                    begin
                        state <= FETCH_IDLE;
                        pc    <= pc + 32'd4;
                    end
                end
                default: state <= FETCH_IDLE;
            endcase

            // word arriving now takes a slot too
            if (q_push)
                start_ok <= !q_full && !q_almost_full;
            else
                start_ok <= !q_full;
        end
    end

endmodule

`default_nettype wire

// File: source/sync_fifo.sv
/* synchronous queue
   register array with read and write pointers, payload chosen by type */

`timescale 1ns/100ps
`default_nettype none

`include "cpu_config.svh"

module sync_fifo
#(
    parameter type payload_t = logic [`WORD_W-1:0],
    parameter int  DEPTH     = `QUEUE_DEPTH
)
(
    input  logic     clk,
    input  logic     reset,
    input  logic     push,
    input  payload_t push_data,
    output logic     full,
    input  logic     pop,
    output logic     empty,
    output payload_t head,
    output logic     almost_full
);
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t           mem [DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [CNT_W-1:0]   count;
    logic               do_push;
    logic               do_pop;

    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    assign full        = (count == CNT_W'(DEPTH));
    assign almost_full = (count == CNT_W'(DEPTH - 1));
    assign empty       = (count == '0);
    assign head        = mem[rd_ptr];

    // storage only, no reset
    always_ff @(posedge clk)
    begin
        if (do_push)
            mem[wr_ptr] <= push_data;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (do_push)
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            // simultaneous push and pop leaves count alone
            if (do_push && !do_pop)
                count <= count + 1'b1;
            else if (do_pop && !do_push)
                count <= count - 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: source/control_unit.sv
/* control unit
   combinational decoder from a fetch packet to the control bundle */

`timescale 1ns/100ps
`default_nettype none

module control_unit
(
    input  cpu_types_pkg::fetch_packet_t packet,
    output cpu_types_pkg::decoded_t      ctrl
);
    import cpu_types_pkg::*;

    word_t instr;

    assign instr = packet.instr;

    always_comb
    begin
        ctrl    = '0;
        ctrl.pc = packet.pc;
        case (opcode_t'(instr[6:0]))
            OP_RTYPE:
            begin
                ctrl.reg_write = 1'b1;
                ctrl.fu_s      = FU_S_ALU;
                case (funct3_alu_t'(instr[14:12]))
                    F3_ADD_SUB: ctrl.alu_op = (instr[31:25] == F7_ALT) ? ALU_SUB : ALU_ADD;
                    F3_SLL:     ctrl.alu_op = ALU_SLL;
                    F3_SLT:     ctrl.alu_op = ALU_SLT;
                    F3_SLTU:    ctrl.alu_op = ALU_SLTU;
                    F3_XOR:     ctrl.alu_op = ALU_XOR;
                    F3_SRL_SRA: ctrl.alu_op = (instr[31:25] == F7_ALT) ? ALU_SRA : ALU_SRL;
                    F3_OR:      ctrl.alu_op = ALU_OR;
                    F3_AND:     ctrl.alu_op = ALU_AND;
                    default:    ctrl.alu_op = ALU_ADD;
                endcase
            end
            OP_ITYPE:
            begin
                ctrl.reg_write = 1'b1;
                ctrl.i_flag    = 1'b1;
                ctrl.imm       = {{20{instr[31]}}, instr[31:20]};
                ctrl.fu_s      = FU_S_ALU;
                // no subtract form with an immediate
                case (funct3_alu_t'(instr[14:12]))
                    F3_ADD_SUB: ctrl.alu_op = ALU_ADD;
                    F3_SLL:     ctrl.alu_op = ALU_SLL;
                    F3_SLT:     ctrl.alu_op = ALU_SLT;
                    F3_SLTU:    ctrl.alu_op = ALU_SLTU;
                    F3_XOR:     ctrl.alu_op = ALU_XOR;
                    F3_SRL_SRA: ctrl.alu_op = (instr[31:25] == F7_ALT) ? ALU_SRA : ALU_SRL;
                    F3_OR:      ctrl.alu_op = ALU_OR;
                    F3_AND:     ctrl.alu_op = ALU_AND;
                    default:    ctrl.alu_op = ALU_ADD;
                endcase
            end
            OP_ITYPE_LW:
            begin
                if (instr[14:12] == F3_WORD)
                begin
                    ctrl.imm        = {{20{instr[31]}}, instr[31:20]};
                    ctrl.reg_write  = 1'b1;
                    ctrl.i_flag     = 1'b1;
                    ctrl.mem_to_reg = 1'b1;
                    ctrl.s_mem_type = MEM_LOAD;
                    ctrl.fu_s       = FU_S_LD_ST;
                end
            end
            OP_STYPE:
            begin
                if (instr[14:12] == F3_WORD)
                begin
                    ctrl.imm        = {{20{instr[31]}}, instr[31:25], instr[11:7]};
                    ctrl.i_flag     = 1'b1;
                    ctrl.s_mem_type = MEM_STORE;
                    ctrl.fu_s       = FU_S_LD_ST;
                end
            end
            OP_BTYPE:
            begin
                ctrl.imm  = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
                ctrl.fu_s = FU_S_BRANCH;
                case (funct3_branch_t'(instr[14:12]))
                    F3_BEQ:  ctrl.branch_type = BR_BEQ;
                    F3_BNE:  ctrl.branch_type = BR_BNE;
                    F3_BLT:  ctrl.branch_type = BR_BLT;
                    F3_BGE:  ctrl.branch_type = BR_BGE;
                    F3_BLTU: ctrl.branch_type = BR_BLTU;
                    F3_BGEU: ctrl.branch_type = BR_BGEU;
                    default: ctrl.branch_type = BR_NONE;
                endcase
            end
            OP_JAL:
            begin
                ctrl.imm       = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
                ctrl.jal       = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.i_flag    = 1'b1;
                ctrl.alu_op    = ALU_ADD;
                ctrl.fu_s      = FU_S_ALU;
            end
            OP_JALR:
            begin
                ctrl.imm       = {{20{instr[31]}}, instr[31:20]};
                ctrl.jalr      = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.i_flag    = 1'b1;
                ctrl.alu_op    = ALU_ADD;
                ctrl.fu_s      = FU_S_ALU;
            end
            OP_LUI:
            begin
                ctrl.imm       = {instr[31:12], 12'b0};
                ctrl.u_load    = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            OP_HALT: ctrl.halt = 1'b1;
            // matrix load and store share the layout, stride is a register index
            OP_LD_M, OP_ST_M:
            begin
                ctrl.imm        = {{21{instr[17]}}, instr[17:7]};
                ctrl.stride     = instr[22:18];
                ctrl.fu_m       = FU_M_LD_ST;
                ctrl.m_mem_type = (instr[6:0] == OP_LD_M) ? MEM_LOAD : MEM_STORE;
                ctrl.matrix_rd  = instr[31:28];
            end
            OP_GEMM_M: ctrl.fu_m = FU_M_GEMM;
            default:   ctrl.fu_s = FU_S_NONE;
        endcase
    end

endmodule

`default_nettype wire

// File: source/decode_stage.sv
/* decode stage
   one instruction per cycle from the instruction queue to the issue queue */

`timescale 1ns/100ps
`default_nettype none

module decode_stage
(
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          in_empty,
    input  cpu_types_pkg::fetch_packet_t  in_head,
    output logic                          in_pop,
    input  logic                          out_full,
    output logic                          out_push,
    output cpu_types_pkg::decoded_t       out_data,
    output logic                          halted
);
    logic advance;

    // pop and push together, nothing held in between
    assign advance  = !in_empty && !out_full && !halted;
    assign in_pop   = advance;
    assign out_push = advance;

    control_unit u_control_unit
    (
        .packet (in_head),
        .ctrl   (out_data)
    );

    // sticky once a halt bundle has gone out
    always_ff @(posedge clk)
    begin
        if (reset)
            halted <= 1'b0;
        else if (advance && out_data.halt)
            halted <= 1'b1;
    end

endmodule

`default_nettype wire

// File: source/frontend_top.sv
/* front end top
   fetch, instruction queue, decode and issue queue in a chain */

`timescale 1ns/100ps
`default_nettype none

`include "cpu_config.svh"

module frontend_top
(
    input  logic                     clk,
    input  logic                     reset,
    output logic                     wb_cyc,
    output logic                     wb_stb,
    output logic                     wb_we,
    output logic [`WORD_W-1:0]       wb_adr,
    output logic [`WORD_BYTES-1:0]   wb_sel,
    input  logic [`WORD_W-1:0]       wb_dat_r,
    input  logic                     wb_ack,
    output logic                     out_valid,
    input  logic                     out_ready,
    output cpu_types_pkg::decoded_t  out_bundle,
    output logic                     halted
);
    import cpu_types_pkg::*;

    fetch_packet_t fetch_data;
    fetch_packet_t instr_head;
    decoded_t      decode_data;
    logic          fetch_push;
    logic          instr_full;
    logic          instr_almost_full;
    logic          instr_empty;
    logic          instr_pop;
    logic          issue_push;
    logic          issue_full;
    logic          issue_empty;

    assign out_valid = !issue_empty;

    instr_fetch u_instr_fetch
    (
        .clk           (clk),
        .reset         (reset),
        .wb_cyc        (wb_cyc),
        .wb_stb        (wb_stb),
        .wb_we         (wb_we),
        .wb_adr        (wb_adr),
        .wb_sel        (wb_sel),
        .wb_dat_r      (wb_dat_r),
        .wb_ack        (wb_ack),
        .q_full        (instr_full),
        .q_almost_full (instr_almost_full),
        .q_push        (fetch_push),
        .q_data        (fetch_data),
        .halted        (halted)
    );

    sync_fifo #(.payload_t(fetch_packet_t), .DEPTH(`QUEUE_DEPTH)) u_instr_queue
    (
        .clk         (clk),
        .reset       (reset),
        .push        (fetch_push),
        .push_data   (fetch_data),
        .full        (instr_full),
        .pop         (instr_pop),
        .empty       (instr_empty),
        .head        (instr_head),
        .almost_full (instr_almost_full)
    );

    decode_stage u_decode_stage
    (
        .clk      (clk),
        .reset    (reset),
        .in_empty (instr_empty),
        .in_head  (instr_head),
        .in_pop   (instr_pop),
        .out_full (issue_full),
        .out_push (issue_push),
        .out_data (decode_data),
        .halted   (halted)
    );

    // the consumer side has no in-flight work, so almost full stays open
    sync_fifo #(.payload_t(decoded_t), .DEPTH(`QUEUE_DEPTH)) u_issue_queue
    (
        .clk         (clk),
        .reset       (reset),
        .push        (issue_push),
        .push_data   (decode_data),
        .full        (issue_full),
        .pop         (out_ready),
        .empty       (issue_empty),
        .head        (out_bundle),
        .almost_full ()
    );

endmodule

`default_nettype wire

// File: verification/frontend_checker.sv
/* front end checker
   watches the DUT ports, compares each bundle with its vector and checks wishbone and halt */

`timescale 1ns/100ps
`default_nettype none

`include "cpu_config.svh"

module frontend_checker
#(
    parameter int NUM_VEC = 1,
    parameter int FIELDS  = 11
)
(
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    wb_cyc,
    input  logic                    wb_stb,
    input  logic                    wb_we,
    input  logic [`WORD_BYTES-1:0]  wb_sel,
    input  logic [`WORD_W-1:0]      wb_adr,
    input  logic                    wb_ack,
    input  logic                    out_valid,
    input  logic                    out_ready,
    input  cpu_types_pkg::decoded_t out_bundle,
    input  logic                    halted,
    input  logic [31:0]             vectors [NUM_VEC*FIELDS],
    output logic                    done,
    output int                      checks,
    output int                      errors
);
    import cpu_types_pkg::*;

    // cycles watched after the halt bundle
    localparam int TAIL_CYCLES = 20;

    int          rx_count = 0;
    int          tail_count = 0;
    int          wait_cycles = 0;
    logic        reset_checked = 1'b0;
    logic        first_adr_checked = 1'b0;
    logic        halt_taken = 1'b0;
    logic        prev_stb = 1'b0;
    logic        prev_ack = 1'b0;
    logic        prev_halted = 1'b0;
    logic [31:0] held_adr = '0;

    initial
    begin
        done   = 1'b0;
        checks = 0;
        errors = 0;
    end

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act)
        begin
            $display("CHECK FAILED %s: expected 0x%h actual 0x%h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_bundle(input int idx);
        int          base;
        int          errors_before;
        logic [31:0] exp_pc;
        base          = idx * FIELDS;
        errors_before = errors;
        exp_pc        = `RESET_PC + 32'(idx) * 32'd4;
        check_value("out_bundle.pc", exp_pc, out_bundle.pc);
        check_value("out_bundle.halt", 32'(vectors[base+1][6]), 32'(out_bundle.halt));
        check_value("out_bundle.i_flag", 32'(vectors[base+1][5]), 32'(out_bundle.i_flag));
        check_value("out_bundle.reg_write", 32'(vectors[base+1][4]), 32'(out_bundle.reg_write));
        check_value("out_bundle.mem_to_reg", 32'(vectors[base+1][3]), 32'(out_bundle.mem_to_reg));
        check_value("out_bundle.jal", 32'(vectors[base+1][2]), 32'(out_bundle.jal));
        check_value("out_bundle.jalr", 32'(vectors[base+1][1]), 32'(out_bundle.jalr));
        check_value("out_bundle.u_load", 32'(vectors[base+1][0]), 32'(out_bundle.u_load));
        check_value("out_bundle.s_mem_type", vectors[base+2], 32'(out_bundle.s_mem_type));
        check_value("out_bundle.alu_op", vectors[base+3], 32'(out_bundle.alu_op));
        check_value("out_bundle.branch_type", vectors[base+4], 32'(out_bundle.branch_type));
        check_value("out_bundle.imm", vectors[base+5], out_bundle.imm);
        check_value("out_bundle.stride", vectors[base+6], 32'(out_bundle.stride));
        check_value("out_bundle.fu_s", vectors[base+7], 32'(out_bundle.fu_s));
        check_value("out_bundle.fu_m", vectors[base+8], 32'(out_bundle.fu_m));
        check_value("out_bundle.m_mem_type", vectors[base+9], 32'(out_bundle.m_mem_type));
        check_value("out_bundle.matrix_rd", vectors[base+10], 32'(out_bundle.matrix_rd));
        checks++;
        $display("bundle %0d instr 0x%h pc 0x%h: %s", idx, vectors[base], out_bundle.pc,
                 (errors == errors_before) ? "ok" : "mismatch");
    endtask

    always @(posedge clk)
    begin
        if (!reset)
        begin
            // first cycle out of reset
            if (!reset_checked)
            begin
                check_value("wb_cyc", 32'd0, 32'(wb_cyc));
                check_value("wb_stb", 32'd0, 32'(wb_stb));
                check_value("out_valid", 32'd0, 32'(out_valid));
                check_value("halted", 32'd0, 32'(halted));
                reset_checked = 1'b1;
                checks++;
                $display("reset state checked");
            end

            if (wb_stb && !first_adr_checked)
            begin
                check_value("wb_adr", `RESET_PC, wb_adr);
                first_adr_checked = 1'b1;
                checks++;
                $display("first fetch address 0x%h", wb_adr);
            end

            // read only, all byte lanes, cyc with stb
            if (wb_stb)
            begin
                check_value("wb_cyc", 32'd1, 32'(wb_cyc));
                check_value("wb_we", 32'd0, 32'(wb_we));
                check_value("wb_sel", 32'({`WORD_BYTES{1'b1}}), 32'(wb_sel));
            end

            // stb and address must hold while waiting for ack
            if (prev_stb && !prev_ack)
            begin
                wait_cycles++;
                check_value("wb_stb", 32'd1, 32'(wb_stb));
                check_value("wb_adr", held_adr, wb_adr);
            end

            // cyc and stb drop for a cycle after ack
            if (prev_ack)
            begin
                check_value("wb_cyc", 32'd0, 32'(wb_cyc));
                check_value("wb_stb", 32'd0, 32'(wb_stb));
            end

            if (wb_stb && !prev_stb && prev_halted)
            begin
                $display("new wishbone cycle started at 0x%h after halt", wb_adr);
                errors++;
            end
            held_adr = wb_adr;

            if (out_valid && out_ready)
            begin
                if (halt_taken)
                begin
                    $display("bundle with pc 0x%h transferred after halt", out_bundle.pc);
                    errors++;
                end
                else if (rx_count >= NUM_VEC)
                begin
                    $display("more bundles than vectors, pc 0x%h", out_bundle.pc);
                    errors++;
                end
                else
                begin
                    check_bundle(rx_count);
                    if (out_bundle.halt)
                    begin
                        check_value("halted", 32'd1, 32'(halted));
                        if (rx_count != NUM_VEC - 1)
                        begin
                            $display("halt came as bundle %0d, last vector is %0d",
                                     rx_count, NUM_VEC - 1);
                            errors++;
                        end
                        halt_taken = 1'b1;
                    end
                    rx_count++;
                end
            end

            if (halt_taken && !done)
            begin
                tail_count++;
                if (tail_count == TAIL_CYCLES)
                begin
                    check_value("halted", 32'd1, 32'(halted));
                    checks++;
                    $display("wishbone address held over %0d wait cycles", wait_cycles);
                    $display("halt held for %0d cycles with no further traffic", tail_count);
                    done = 1'b1;
                end
            end

            prev_stb    = wb_stb;
            prev_ack    = wb_ack;
            prev_halted = halted;
        end
    end

endmodule

`default_nettype wire

// File: verification/tb_frontend.sv
/* front end testbench
   clock, reset, wishbone memory model, random back-pressure and the DUT */

`timescale 1ns/100ps
`default_nettype none

`include "cpu_config.svh"

module tb_frontend;
    import cpu_types_pkg::*;

    localparam int NUM_VEC       = 25;
    localparam int FIELDS        = 11;
    localparam int CLK_PERIOD    = 20;
    localparam int MARGIN_CYCLES = 100;

    logic                   clk;
    logic                   reset;
    logic                   wb_cyc;
    logic                   wb_stb;
    logic                   wb_we;
    logic [`WORD_W-1:0]     wb_adr;
    logic [`WORD_BYTES-1:0] wb_sel;
    logic [`WORD_W-1:0]     wb_dat_r;
    logic                   wb_ack;
    logic                   out_valid;
    logic                   out_ready;
    decoded_t               out_bundle;
    logic                   halted;
    logic [31:0]            vectors [NUM_VEC*FIELDS];
    logic                   done;
    int                     checks;
    int                     errors;
    logic                   pending;
    int                     wait_left;

    always #(CLK_PERIOD / 2) clk = ~clk;

    // instruction words sit at consecutive addresses, the rest is filled
    function automatic logic [31:0] read_word(input logic [31:0] adr);
        logic [31:0] offset;
        offset = adr - `RESET_PC;
        if (offset[31:2] < 30'(NUM_VEC))
            return vectors[int'(offset[31:2]) * FIELDS];
        else
            return ~adr;
    endfunction

    // wishbone slave with 0 to 3 wait cycles
    always @(posedge clk)
    begin
        #1;
        if (reset)
        begin
            wb_ack  = 1'b0;
            pending = 1'b0;
        end
        else if (wb_ack)
        begin
            wb_ack  = 1'b0;
            pending = 1'b0;
        end
        else if (wb_stb)
        begin
            if (!pending)
            begin
                pending   = 1'b1;
                wait_left = int'($urandom % 4);
            end
            if (wait_left == 0)
            begin
                wb_ack   = 1'b1;
                wb_dat_r = read_word(wb_adr);
            end
            else
                wait_left--;
        end
    end

    always @(posedge clk)
    begin
        #1;
        out_ready = 1'($urandom % 2);
    end

    frontend_top u_dut
    (
        .clk        (clk),
        .reset      (reset),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_we      (wb_we),
        .wb_adr     (wb_adr),
        .wb_sel     (wb_sel),
        .wb_dat_r   (wb_dat_r),
        .wb_ack     (wb_ack),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_bundle (out_bundle),
        .halted     (halted)
    );

    frontend_checker #(.NUM_VEC(NUM_VEC), .FIELDS(FIELDS)) u_checker
    (
        .clk        (clk),
        .reset      (reset),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_we      (wb_we),
        .wb_sel     (wb_sel),
        .wb_adr     (wb_adr),
        .wb_ack     (wb_ack),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_bundle (out_bundle),
        .halted     (halted),
        .vectors    (vectors),
        .done       (done),
        .checks     (checks),
        .errors     (errors)
    );

    initial
    begin
        clk       = 1'b0;
        reset     = 1'b1;
        wb_dat_r  = '0;
        wb_ack    = 1'b0;
        out_ready = 1'b0;
        pending   = 1'b0;
        wait_left = 0;
        void'($urandom(4126));
        $readmemh("verification/frontend_vectors.hex", vectors);
        repeat (3) @(posedge clk);
        #1 reset = 1'b0;
        wait (done == 1'b1);
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

    // budget of six cycles per instruction plus a margin
    initial
    begin
        #((NUM_VEC * 6 + MARGIN_CYCLES) * CLK_PERIOD);
        $display("timeout: halt bundle and tail not seen within %0d cycles",
                 NUM_VEC * 6 + MARGIN_CYCLES);
        $display("Verification failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: verification/frontend_vectors.hex
// instr flags s_mem alu_op branch imm stride fu_s fu_m m_mem matrix_rd, one instruction per line
// flags bits 6..0 are halt i_flag reg_write mem_to_reg jal jalr u_load
FFB00093 30 0 0 0 FFFFFFFB 0  1 0 0 0
002081B3 10 0 0 0 00000000 0  1 0 0 0
40208233 10 0 1 0 00000000 0  1 0 0 0
4020D2B3 10 0 4 0 00000000 0  1 0 0 0
0020D5B3 10 0 3 0 00000000 0  1 0 0 0
0020B333 10 0 9 0 00000000 0  1 0 0 0
0020F633 10 0 5 0 00000000 0  1 0 0 0
7FF0C393 30 0 7 0 000007FF 0  1 0 0 0
4030D413 30 0 4 0 00000403 0  1 0 0 0
FFF0A693 30 0 8 0 FFFFFFFF 0  1 0 0 0
00812483 38 1 0 0 00000008 0  2 0 0 0
FE312E23 20 2 0 0 FFFFFFFC 0  2 0 0 0
00010283 00 0 0 0 00000000 0  0 0 0 0
00208863 00 0 0 1 00000010 0  3 0 0 0
00209263 00 0 0 2 00000004 0  3 0 0 0
0220D063 00 0 0 4 00000020 0  3 0 0 0
FE20ECE3 00 0 0 5 FFFFFFF8 0  3 0 0 0
001000EF 34 0 0 0 00000800 0  1 0 0 0
00C280E7 32 0 0 0 0000000C 0  1 0 0 0
ABCDE537 11 0 0 0 ABCDE000 0  0 0 0 0
3017F847 00 0 0 0 FFFFFFF0 5  0 1 1 3
A07C0857 00 0 0 0 00000010 1F 0 1 2 A
12345677 00 0 0 0 00000000 0  0 2 0 0
0000000B 00 0 0 0 00000000 0  0 0 0 0
0000007F 40 0 0 0 00000000 0  0 0 0 0

// File: compile.f
+incdir+source
source/cpu_types_pkg.sv
source/instr_fetch.sv
source/sync_fifo.sv
source/control_unit.sv
source/decode_stage.sv
source/frontend_top.sv
verification/frontend_checker.sv
verification/tb_frontend.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the front end testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f compile.f --top-module tb_frontend -o sim_frontend

output=$(./obj_dir/sim_frontend)
echo "$output"

if echo "$output" | grep -qx "Verification passed"; then
    exit 0
else
    exit 1
fi
